/* board_tests.txt */
// columns, all hex: chip  cclk_delay  cycles_per_line  lines_per_frame  config_byte
// cclk_delay is extra cycles of low cclk after the cpu reset hold
0  14   3F  138  C0
1  55   41  107  C1
2  0    40  106  C2
3  1F4  41  138  C3

/* board_top.sv */
`timescale 1ns/100ps

module board_top (
    input  logic       sys_clock,
    input  logic       arst_n,
    input  logic [1:0] chip,       // model straps from the mcu
    input  logic       cclk,       // mcu config clock, high once it is done
    output logic       phi,        // cpu clock
    output logic       cpu_reset,
    output logic       hsync,
    output logic       vsync,
    output logic       active,
    output logic       tx          // serial toward the mcu
);

    logic                    phi_tick;
    logic                    raster_restart;
    logic                    tx_strobe;
    logic                    tx_busy;
    vic_pkg::chip_t          chip_sel;
    vic_pkg::config_byte_t   tx_byte;
    vic_pkg::raster_status_t raster_status;

    phi_clock_gen u_phi (
        .sys_clock (sys_clock),
        .arst_n    (arst_n),
        .phi       (phi),
        .phi_tick  (phi_tick),
        .cpu_reset (cpu_reset)
    );

    raster_timing u_raster (
        .sys_clock      (sys_clock),
        .arst_n         (arst_n),
        .phi_tick       (phi_tick),
        .raster_restart (raster_restart),
        .chip_sel       (chip_sel),
        .raster_status  (raster_status)
    );

    config_reporter u_config (
        .sys_clock (sys_clock), .arst_n (arst_n), .chip (chip), .tx_busy (tx_busy),
        .chip_sel (chip_sel), .raster_restart (raster_restart),
        .tx_byte (tx_byte), .tx_strobe (tx_strobe)
    );

    mcu_serial_tx u_mcu_tx (
        .sys_clock (sys_clock), .arst_n (arst_n), .cclk (cclk),
        .tx_byte (tx_byte), .tx_strobe (tx_strobe), .tx (tx), .tx_busy (tx_busy)
    );

    assign hsync  = raster_status.hsync;   // fan out to the video pins
    assign vsync  = raster_status.vsync;
    assign active = raster_status.active;

endmodule

/* board_top_chk.sv */
`timescale 1ns/100ps

`include "vic_settings.svh"

module board_top_chk (
    input logic sys_clock,
    input logic arst_n,
    input logic hsync,
    input logic raster_restart,
    input logic phi_tick,
    input logic cpu_reset,
    input logic tx,
    input logic tx_busy
);

    int unsigned fail_count = 0;  // assertion failures so far
    logic [7:0]  hs_len;          // high samples of the current hsync pulse
    logic        hs_cut;          // pulse shortened or stretched by a restart

    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            hs_len <= '0;
            hs_cut <= 1'b0;
        end else begin
            hs_len <= hsync ? hs_len + 1'b1 : '0;
            if (raster_restart) begin
                hs_cut <= 1'b1;
            end else if (!hsync && hs_len != '0) begin
                hs_cut <= 1'b0;   // that pulse has ended
            end
        end
    end

    // full sync pulse is HSYNC_CYC phi cycles long
    hsync_width: assert property (@(posedge sys_clock) disable iff (!arst_n)
        $fell(hsync) && !hs_cut |-> hs_len == 8'(`HSYNC_CYC * `PHI_DIV))
        else begin
            $error("hsync pulse lasted %0d cycles", hs_len);
            fail_count++;
        end

    // serial line idles high whenever the link is free
    tx_idle: assert property (@(posedge sys_clock) disable iff (!arst_n) !tx_busy |-> tx)
        else begin
            $error("tx low while the link is idle");
            fail_count++;
        end

    phi_tick_single: assert property (@(posedge sys_clock) disable iff (!arst_n)
        phi_tick |=> !phi_tick)
        else begin
            $error("phi_tick high on two cycles in a row");
            fail_count++;
        end

    // cpu reset is released once per board reset
    cpu_reset_once: assert property (@(posedge sys_clock) disable iff (!arst_n)
        !cpu_reset |=> !cpu_reset)
        else begin
            $error("cpu_reset rose again");
            fail_count++;
        end

endmodule

bind board_top board_top_chk u_chk (
    .sys_clock      (sys_clock),
    .arst_n         (arst_n),
    .hsync          (hsync),
    .raster_restart (raster_restart),
    .phi_tick       (phi_tick),
    .cpu_reset      (cpu_reset),
    .tx             (tx),
    .tx_busy        (tx_busy)
);

/* board_top_tb.sv */
`timescale 1ns/100ps

`include "vic_settings.svh"

module board_top_tb;

    localparam int PIN_TX      = 0;
    localparam int PIN_HSYNC   = 1;
    localparam int PIN_VSYNC   = 2;
    localparam int FIELDS      = 5;        // words per line of the data file
    localparam int MAX_CASES   = 8;
    localparam int FRAME_LIMIT = 700000;   // longer than any frame

    logic        sys_clock;
    logic        arst_n;
    logic [1:0]  chip;
    logic        cclk;
    logic        phi;
    logic        cpu_reset;
    logic        hsync;
    logic        vsync;
    logic        active;
    logic        tx;
    logic [15:0] case_mem [0:FIELDS*MAX_CASES-1];
    int          num_cases;

    board_top DUT (
        .sys_clock (sys_clock),
        .arst_n    (arst_n),
        .chip      (chip),
        .cclk      (cclk),
        .phi       (phi),
        .cpu_reset (cpu_reset),
        .hsync     (hsync),
        .vsync     (vsync),
        .active    (active),
        .tx        (tx)
    );

    initial begin
        sys_clock = 1'b0;
        forever #50 sys_clock = ~sys_clock;   // 100 ns period
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // a failed bound assertion ends the run right away
    always @(negedge sys_clock) begin
        if (DUT.u_chk.fail_count != 0)
            stop_run($sformatf("a bound assertion failed, %0d failures so far",
                               DUT.u_chk.fail_count));
    end

    function automatic logic pin_level(input int sel);
        case (sel)
            PIN_TX:    return tx;
            PIN_HSYNC: return hsync;
            default:   return vsync;
        endcase
    endfunction

    function automatic string pin_name(input int sel);
        case (sel)
            PIN_TX:    return "tx";
            PIN_HSYNC: return "hsync";
            default:   return "vsync";
        endcase
    endfunction

    // steps falling edges until the pin shows the level and counts the steps in n
    task automatic wait_for_level(input int sel, input logic level, input int limit,
                                  output int n);
        n = 0;
        do begin
            @(negedge sys_clock);
            n++;
            if (n > limit)
                stop_run($sformatf("timeout after %0d cycles waiting for %s to be %0b",
                                   limit, pin_name(sel), level));
        end while (pin_level(sel) !== level);
    endtask

    // 8n1 frame sampled in the middle of each bit
    task automatic receive_byte(input int limit, output int wait_n, output logic [7:0] data);
        wait_for_level(PIN_TX, 1'b0, limit, wait_n);
        repeat (`BAUD_DIV / 2 - 1) @(negedge sys_clock);
        assert (tx === 1'b0) else stop_run($sformatf("ERROR: tx start bit got %h expected 0", tx));
        for (int i = 0; i < 8; i++) begin
            repeat (`BAUD_DIV) @(negedge sys_clock);
            data[i] = tx;   // lsb first
        end
        repeat (`BAUD_DIV) @(negedge sys_clock);
        assert (tx === 1'b1) else stop_run($sformatf("ERROR: tx stop bit got %h expected 1", tx));
    endtask

    // checks one whole frame cycle by cycle against the beam position
    task automatic check_frame(input int cyc, input int lines);
        int   line_len;
        int   frame_len;
        int   n;
        int   pos;
        int   x;
        int   ln;
        logic exp_h;
        logic exp_v;
        logic exp_a;
        line_len  = cyc * `PHI_DIV;
        frame_len = line_len * lines;
        wait_for_level(PIN_VSYNC, 1'b0, frame_len, n);
        wait_for_level(PIN_VSYNC, 1'b1, frame_len, n);   // start of line 0
        for (int c = 1; c <= frame_len; c++) begin
            @(negedge sys_clock);
            pos   = c % frame_len;   // last step lands on the next frame start
            x     = (pos % line_len) / `PHI_DIV;
            ln    = pos / line_len;
            exp_h = (x < `HSYNC_CYC);
            exp_v = (ln < `VSYNC_LINES);
            exp_a = (x >= `H_ACT_START) && (x < `H_ACT_END) &&
                    (ln >= `V_ACT_START) && (ln < lines - `V_ACT_BORDER);
            assert (hsync === exp_h) else stop_run($sformatf(
                "ERROR: hsync got %h expected %h at frame cycle %0d", hsync, exp_h, c));
            assert (vsync === exp_v) else stop_run($sformatf(
                "ERROR: vsync got %h expected %h at frame cycle %0d", vsync, exp_v, c));
            assert (active === exp_a) else stop_run($sformatf(
                "ERROR: active got %h expected %h at frame cycle %0d", active, exp_a, c));
        end
    endtask

    task automatic run_case(input int idx);
        logic [1:0] model;
        logic [7:0] exp_byte;
        logic [7:0] got;
        logic       exp_phi;
        logic       exp_rst;
        int         delay;
        int         n;
        int         glitch;
        model    = case_mem[idx*FIELDS][1:0];
        delay    = case_mem[idx*FIELDS+1];
        exp_byte = case_mem[idx*FIELDS+4][7:0];
        assert (exp_byte == {`CONFIG_TAG, 2'b00, model})
            else stop_run($sformatf("config byte %h on data line %0d breaks the tag rule",
                                    exp_byte, idx));
        @(negedge sys_clock);
        arst_n = 1'b0;
        chip   = model;   // straps settle during reset
        cclk   = 1'b0;
        repeat (4) begin
            @(negedge sys_clock);
            assert ({tx, hsync, vsync, active} === 4'b1000) else stop_run($sformatf(
                "ERROR: {tx,hsync,vsync,active} got %h expected 8 in reset",
                {tx, hsync, vsync, active}));
        end
        arst_n = 1'b1;
        for (int k = 1; k <= `CPU_RESET_PHI * `PHI_DIV; k++) begin
            @(negedge sys_clock);
            exp_phi = ((k % `PHI_DIV) >= `PHI_DIV / 2);   // low half of each phi cycle first
            exp_rst = (k < `CPU_RESET_PHI * `PHI_DIV);
            assert (phi === exp_phi) else stop_run($sformatf(
                "ERROR: phi got %h expected %h at cycle %0d after reset", phi, exp_phi, k));
            assert (cpu_reset === exp_rst) else stop_run($sformatf(
                "ERROR: cpu_reset got %h expected %h at cycle %0d after reset",
                cpu_reset, exp_rst, k));
            assert (tx === 1'b1) else stop_run($sformatf("ERROR: tx got %h expected 1", tx));
        end
        repeat (delay) begin
            @(negedge sys_clock);
            assert (tx === 1'b1) else stop_run($sformatf("ERROR: tx got %h expected 1", tx));
        end
        glitch = $urandom_range(`CCLK_STABLE - 4, 1);
        cclk   = 1'b1;
        repeat (glitch) @(negedge sys_clock);
        cclk = 1'b0;   // one low sample restarts the stability count
        @(negedge sys_clock);
        cclk = 1'b1;
        receive_byte(`CCLK_STABLE + 16, n, got);
        assert (n == `CCLK_STABLE + 1) else stop_run($sformatf(
            "ERROR: tx start bit cycle got %h expected %h", n, `CCLK_STABLE + 1));
        assert (got === exp_byte) else stop_run($sformatf(
            "ERROR: tx byte got %h expected %h", got, exp_byte));
        check_frame(case_mem[idx*FIELDS+2], case_mem[idx*FIELDS+3]);
    endtask

    // switch to the model of data line idx in the middle of a frame
    task automatic change_model(input int idx);
        logic [7:0] exp_byte;
        logic [7:0] got;
        int         line_len;
        int         n;
        int         n_tx;
        int         hi;
        int         lo;
        exp_byte = case_mem[idx*FIELDS+4][7:0];
        line_len = case_mem[idx*FIELDS+2] * `PHI_DIV;
        wait_for_level(PIN_VSYNC, 1'b1, FRAME_LIMIT, n);
        wait_for_level(PIN_VSYNC, 1'b0, FRAME_LIMIT, n);
        wait_for_level(PIN_HSYNC, 1'b0, FRAME_LIMIT, n);
        repeat ($urandom_range(1500, 1)) @(negedge sys_clock);   // inside the hsync low part
        chip = case_mem[idx*FIELDS][1:0];
        fork
            begin
                receive_byte(`BAUD_DIV, n_tx, got);
                assert (got === exp_byte) else stop_run($sformatf(
                    "ERROR: tx byte got %h expected %h", got, exp_byte));
                repeat (3 * 10 * `BAUD_DIV) begin   // no repeat of the report
                    @(negedge sys_clock);
                    assert (tx === 1'b1) else stop_run($sformatf(
                        "ERROR: tx got %h expected 1 after the config byte", tx));
                end
            end
            begin
                wait_for_level(PIN_HSYNC, 1'b1, line_len, n);
                assert (vsync === 1'b1) else stop_run($sformatf(
                    "ERROR: vsync got %h expected 1 after the restart", vsync));
                wait_for_level(PIN_HSYNC, 1'b0, line_len, n);
                wait_for_level(PIN_HSYNC, 1'b1, line_len, n);   // first full line
                wait_for_level(PIN_HSYNC, 1'b0, line_len, hi);
                wait_for_level(PIN_HSYNC, 1'b1, line_len, lo);
                assert (hi == `HSYNC_CYC * `PHI_DIV) else stop_run($sformatf(
                    "ERROR: hsync width got %h expected %h", hi, `HSYNC_CYC * `PHI_DIV));
                assert (hi + lo == line_len) else stop_run($sformatf(
                    "ERROR: hsync period got %h expected %h", hi + lo, line_len));
            end
        join
    endtask

    initial begin
        arst_n = 1'b0;
        chip   = 2'b00;
        cclk   = 1'b0;
        void'($urandom(24316));
        for (int i = 0; i < FIELDS * MAX_CASES; i++)
            case_mem[i] = 16'hffff;   // marks unused entries
        $readmemh("board_tests.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] !== 16'hffff)
            num_cases++;
        assert (num_cases > 0) else stop_run("no test lines found in board_tests.txt");
        for (int i = 0; i < num_cases; i++)
            run_case(i);
        change_model(0);   // last data line uses another model than the first
        if (DUT.u_chk.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_run($sformatf("%0d bound assertion failures", DUT.u_chk.fail_count));
        end
    end

endmodule

/* compile.f */
+incdir+.
vic_pkg.sv
phi_clock_gen.sv
raster_timing.sv
config_reporter.sv
mcu_serial_tx.sv
board_top.sv
board_top_chk.sv
board_top_tb.sv

/* config_reporter.sv */
`timescale 1ns/100ps

`include "vic_settings.svh"

module config_reporter (
    input  logic                  sys_clock,
    input  logic                  arst_n,
    input  logic [1:0]            chip,
    input  logic                  tx_busy,
    output vic_pkg::chip_t        chip_sel,
    output logic                  raster_restart,
    output vic_pkg::config_byte_t tx_byte,
    output logic                  tx_strobe
);

    vic_pkg::chip_t chip_q;     // pin sample
    logic           primed;     // chip_q holds a real sample
    logic           init_done;  // first report already queued
    logic           pending;    // a report waits for the link
    logic           change;

    // forced once after reset, then on every model difference
    assign change = primed && (!init_done || (chip_q != chip_sel));

    // release when the link is free, never in a cycle that rewrites the byte
    assign tx_strobe = pending && !tx_busy && !change;

    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            chip_q         <= vic_pkg::CHIP_PAL;
            primed         <= 1'b0;
            init_done      <= 1'b0;
            chip_sel       <= vic_pkg::CHIP_PAL;
            raster_restart <= 1'b0;
            pending        <= 1'b0;
        end else begin
            chip_q         <= vic_pkg::chip_t'(chip); // sampled every cycle
            primed         <= 1'b1;
            raster_restart <= change;                 // single cycle pulse
            if (change) begin
                init_done <= 1'b1;
                chip_sel  <= chip_q;
                pending   <= 1'b1;   // later change only refreshes the byte
            end else if (tx_strobe) begin
                pending   <= 1'b0;
            end
        end
    end

    // byte content follows the latest model
    always_ff @(posedge sys_clock) begin
        if (change) begin
            tx_byte.tag      <= `CONFIG_TAG;
            tx_byte.reserved <= 2'b00;
            tx_byte.chip     <= chip_q;
        end
    end

endmodule

/* mcu_serial_tx.sv */
`timescale 1ns/100ps

`include "vic_settings.svh"

module mcu_serial_tx (
    input  logic                  sys_clock,
    input  logic                  arst_n,
    input  logic                  cclk,
    input  vic_pkg::config_byte_t tx_byte,
    input  logic                  tx_strobe,
    output logic                  tx,
    output logic                  tx_busy
);

    localparam int CCLK_W = $clog2(`CCLK_STABLE);
    localparam int BAUD_W = $clog2(`BAUD_DIV);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t         state;
    logic [CCLK_W-1:0] cclk_cnt;  // consecutive high cclk samples
    logic              ready;     // mcu has finished configuring the fpga
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_idx;   // data bit being sent
    logic [7:0]        shift;     // byte on its way out, lsb at bit 0
    logic              bit_end;

    // mcu holds cclk low while it is busy, wait for a stable high
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            cclk_cnt <= '0;
            ready    <= 1'b0;
        end else if (!cclk) begin
            cclk_cnt <= '0;    // any glitch restarts the wait
            ready    <= 1'b0;
        end else if (cclk_cnt == CCLK_W'(`CCLK_STABLE - 1)) begin
            ready    <= 1'b1;
        end else begin
            cclk_cnt <= cclk_cnt + 1'b1;
        end
    end

    assign tx_busy = !ready || (state != TX_IDLE);
    assign bit_end = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));

    // 8n1 framing
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;   // line idles high
        end else begin
            baud_cnt <= (state == TX_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
            case (state)
                TX_IDLE: if (tx_strobe) begin   // strobe only comes when free
                    state <= TX_START;
                    tx    <= 1'b0;              // start bit
                end
                TX_START: if (bit_end) begin
                    state   <= TX_DATA;
                    bit_idx <= '0;
                    tx      <= shift[0];
                end
                TX_DATA: if (bit_end) begin
                    if (bit_idx == 3'd7) begin
                        state <= TX_STOP;
                        tx    <= 1'b1;          // stop bit
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        tx      <= shift[1];    // next bit before the shift lands
                    end
                end
                default: if (bit_end) begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // payload shifter
    always_ff @(posedge sys_clock) begin
        if (state == TX_IDLE && tx_strobe) begin
            shift <= tx_byte;
        end else if (state == TX_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

endmodule

/* phi_clock_gen.sv */
`timescale 1ns/100ps

`include "vic_settings.svh"

module phi_clock_gen (
    input  logic sys_clock,
    input  logic arst_n,
    output logic phi,
    output logic phi_tick,
    output logic cpu_reset
);

    localparam int PHI_W = $clog2(`PHI_DIV);
    localparam int RST_W = $clog2(`CPU_RESET_PHI);

    logic [PHI_W-1:0] phi_cnt;   // position inside the phi cycle
    logic [RST_W-1:0] rst_cnt;   // phi cycles seen while cpu held in reset

    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            phi_cnt <= '0;
        end else begin
            phi_cnt <= phi_tick ? '0 : phi_cnt + 1'b1; // wraps at PHI_DIV
        end
    end

    assign phi      = (phi_cnt >= PHI_W'(`PHI_DIV / 2)); // low half first
    assign phi_tick = (phi_cnt == PHI_W'(`PHI_DIV - 1)); // last sys cycle of phi

    // count phi cycles, release cpu on the last one and then hold still
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            rst_cnt   <= '0;
            cpu_reset <= 1'b1;
        end else if (cpu_reset && phi_tick) begin
            if (rst_cnt == RST_W'(`CPU_RESET_PHI - 1)) begin
                cpu_reset <= 1'b0;  // 8 phi cycles done, counter stops here
            end else begin
                rst_cnt <= rst_cnt + 1'b1;
            end
        end
    end

endmodule

/* raster_timing.sv */
`timescale 1ns/100ps

`include "vic_settings.svh"

module raster_timing (
    input  logic                    sys_clock,
    input  logic                    arst_n,
    input  logic                    phi_tick,
    input  logic                    raster_restart,
    input  vic_pkg::chip_t          chip_sel,
    output vic_pkg::raster_status_t raster_status
);

    vic_pkg::xpos_t   line_cyc;   // phi cycles per line for the model
    vic_pkg::raster_t line_cnt;   // lines per frame for the model
    vic_pkg::xpos_t   xpos;
    vic_pkg::raster_t raster;
    logic             h_win;
    logic             v_win;

    // geometry lookup
    always_comb begin
        case (chip_sel)
            vic_pkg::CHIP_PAL: begin
                line_cyc = vic_pkg::xpos_t'(`CYC_PAL);
                line_cnt = vic_pkg::raster_t'(`LINES_PAL);
            end
            vic_pkg::CHIP_NTSC: begin
                line_cyc = vic_pkg::xpos_t'(`CYC_NTSC);
                line_cnt = vic_pkg::raster_t'(`LINES_NTSC);
            end
            vic_pkg::CHIP_NTSC_OLD: begin
                line_cyc = vic_pkg::xpos_t'(`CYC_NTSC_OLD);
                line_cnt = vic_pkg::raster_t'(`LINES_NTSC_OLD);
            end
            default: begin                                    // paln
                line_cyc = vic_pkg::xpos_t'(`CYC_PALN);
                line_cnt = vic_pkg::raster_t'(`LINES_PALN);
            end
        endcase
    end

    // beam position, restart wins over the phi advance
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            xpos   <= '0;
            raster <= '0;
        end else if (raster_restart) begin
            xpos   <= '0;   // phi phase keeps running untouched
            raster <= '0;
        end else if (phi_tick) begin
            if (xpos >= line_cyc - 1'b1) begin
                xpos <= '0;
                if (raster >= line_cnt - 1'b1) begin
                    raster <= '0;  // new frame
                end else begin
                    raster <= raster + 1'b1;
                end
            end else begin
                xpos <= xpos + 1'b1;
            end
        end
    end

    assign h_win = (xpos >= vic_pkg::xpos_t'(`H_ACT_START)) &&
                   (xpos <  vic_pkg::xpos_t'(`H_ACT_END));
    // vertical window closes a fixed border before the frame end
    assign v_win = (raster >= vic_pkg::raster_t'(`V_ACT_START)) &&
                   (raster <  line_cnt - vic_pkg::raster_t'(`V_ACT_BORDER));

    // registered levels, one cycle behind the counters
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            raster_status <= '0;
        end else begin
            raster_status.hsync  <= (xpos < vic_pkg::xpos_t'(`HSYNC_CYC));
            raster_status.vsync  <= (raster < vic_pkg::raster_t'(`VSYNC_LINES));
            raster_status.active <= h_win && v_win;
        end
    end

endmodule

/* vic_pkg.sv */
package vic_pkg;

    // chip model as strapped on the board pins
    typedef enum logic [1:0] {
        CHIP_PAL      = 2'd0,
        CHIP_NTSC     = 2'd1,
        CHIP_NTSC_OLD = 2'd2,
        CHIP_PALN     = 2'd3
    } chip_t;

    typedef logic [6:0] xpos_t;    // phi cycle within a line
    typedef logic [8:0] raster_t;  // line within a frame

    // byte reported to the mcu, tag in the top nibble
    typedef struct packed {
        logic [3:0] tag;
        logic [1:0] reserved;      // always zero
        chip_t      chip;
    } config_byte_t;

    // sync and window levels leaving the raster block
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
    } raster_status_t;

endpackage

/* vic_settings.svh */
`ifndef VIC_SETTINGS_SVH
`define VIC_SETTINGS_SVH

// clocking
`define PHI_DIV        32     // sys_clock cycles per phi cycle
`define BAUD_DIV       16     // sys_clock cycles per serial bit
`define CCLK_STABLE    64     // high cclk samples before mcu link is usable
`define CPU_RESET_PHI  8      // phi cycles of cpu reset hold

// raster geometry per chip model, phi cycles per line and lines per frame
`define CYC_PAL        63
`define LINES_PAL      312
`define CYC_NTSC       65
`define LINES_NTSC     263
`define CYC_NTSC_OLD   64
`define LINES_NTSC_OLD 262
`define CYC_PALN       65
`define LINES_PALN     312

`define HSYNC_CYC      4      // hsync on phi cycles 0..3
`define VSYNC_LINES    3      // vsync on lines 0..2
`define H_ACT_START    16     // first visible phi cycle
`define H_ACT_END      56     // first phi cycle past the visible part
`define V_ACT_START    16     // first visible line
`define V_ACT_BORDER   16     // blank lines at the bottom of the frame

`define CONFIG_TAG     4'hC   // marks a config byte for the mcu

`endif
